// ==== verilog/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// data and address width
`define XLEN 32

// register index width
`define REG_ADDR_W 5

// architectural register count
`define NUM_REGS 32

// byte enables for one word
`define SEL_W 4

// ----------------------------------------
// fixed words
// ----------------------------------------

// first fetch after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0 used as the bubble word
`define NOP_INST 32'h0000_0013

`endif

// ==== verilog/rv_isa_pkg.sv ====
`include "rv_defines.svh"

package rv_isa_pkg;

	// ----------------------------------------
	// major opcodes of the kept subset
	// ----------------------------------------
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_jal    = 7'b1101111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_e;

	// x0 index, reads zero and never forwards
	localparam logic [`REG_ADDR_W-1:0] reg_zero = '0;

	// funct3 of the alu group
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// funct3 of branches
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;

	// lw / sw width code, only word accesses kept
	localparam logic [2:0] f3_word = 3'b010;

	// funct7 of sub and sra / srai
	localparam logic [6:0] f7_alt = 7'b0100000;

	// ----------------------------------------
	// execute controls
	// ----------------------------------------
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sll, alu_srl, alu_sra, alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		br_none, br_eq, br_ne, br_lt, br_ge, br_jal
	} br_op_e;

endpackage

// ==== verilog/rv_pipe_pkg.sv ====
`include "rv_defines.svh"

package rv_pipe_pkg;

	// ----------------------------------------
	// stage payloads
	// ----------------------------------------

	// fetch to decode
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] inst;
	} if_id_t;

	// decode to execute, operands already forwarded
	typedef struct packed {
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       op_a;
		logic [`XLEN-1:0]       op_b;
		logic [`XLEN-1:0]       store_data;
		logic [`REG_ADDR_W-1:0] rd;
		logic                   we;
		rv_isa_pkg::alu_op_e    alu_op;
		rv_isa_pkg::br_op_e     br_op;
		logic                   is_load;
		logic                   is_store;
		logic [`XLEN-1:0]       br_off;
	} id_ex_t;

	// execute to memory
	typedef struct packed {
		logic [`XLEN-1:0]       result;
		logic [`XLEN-1:0]       store_data;
		logic [`REG_ADDR_W-1:0] rd;
		logic                   we;
		logic                   is_load;
		logic                   is_store;
	} ex_mem_t;

	// memory to writeback
	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rd;
		logic                   we;
		logic [`XLEN-1:0]       wdata;
	} mem_wb_t;

	// hold request, one bit per stage register
	typedef struct packed {
		logic pc;
		logic if_id;
		logic id_ex;
		logic ex_mem;
		logic mem_wb;
	} stall_t;

	// bubbles, all zero means add with no write and no branch
	localparam if_id_t  if_id_bubble  = '{pc: `RESET_PC, inst: `NOP_INST};
	localparam id_ex_t  id_ex_bubble  = '0;
	localparam ex_mem_t ex_mem_bubble = '0;
	localparam mem_wb_t mem_wb_bubble = '0;

endpackage

// ==== verilog/rv_ifs.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

// two register read ports, data returns combinationally
interface rf_read_if;
	logic                   re1;
	logic                   re2;
	logic [`REG_ADDR_W-1:0] raddr1;
	logic [`REG_ADDR_W-1:0] raddr2;
	logic [`XLEN-1:0]       rdata1;
	logic [`XLEN-1:0]       rdata2;

	modport decode  (output re1, re2, raddr1, raddr2, input rdata1, rdata2);
	modport regfile (input re1, re2, raddr1, raddr2, output rdata1, rdata2);
endinterface

// result of a younger stage offered back to decode
interface fwd_if;
	logic [`REG_ADDR_W-1:0] rd;
	logic                   we;
	logic [`XLEN-1:0]       data;
	logic                   is_load;

	modport producer (output rd, we, data, is_load);
	modport consumer (input rd, we, data, is_load);
endinterface

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = rv_pipe_pkg::if_id_t,
	parameter payload_t bubble = rv_pipe_pkg::if_id_bubble
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     stall_i,
	input  logic     flush_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// flush beats stall, so a redirect never waits on a hazard
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			q_o <= bubble;
		end else if (flush_i) begin
			q_o <= bubble;
		end else if (!stall_i) begin
			q_o <= d_i;
		end
		// otherwise hold for the stalled stage
	end

endmodule

// ==== verilog/rv_fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_fetch_ctrl (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                load_use_i,
	input  logic                redirect_i,
	input  logic [`XLEN-1:0]    target_i,
	output logic [`XLEN-1:0]    pc_o,
	output logic                fetch_en_o,
	output rv_pipe_pkg::stall_t stall_o,
	output logic                flush_o
);

	logic hold;

	// ----------------------------------------
	// stall / flush control
	// ----------------------------------------

	// redirect wins, the stalled decode slot is wrong path anyway
	assign hold = load_use_i & ~redirect_i;

	// front end holds, id_ex takes a bubble at the top level
	// back end never holds, no memory back-pressure
	assign stall_o = '{
		pc:     hold,
		if_id:  hold,
		id_ex:  1'b0,
		ex_mem: 1'b0,
		mem_wb: 1'b0
	};

	// kill if_id and id_ex on a taken branch or jal
	assign flush_o = redirect_i;

	// ----------------------------------------
	// program counter
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_o       <= `RESET_PC;
			fetch_en_o <= 1'b0;
		end else begin
			fetch_en_o <= 1'b1;
			if (redirect_i) begin
				pc_o <= target_i;
			end else if (fetch_en_o && !stall_o.pc) begin
				pc_o <= pc_o + `XLEN'd4;
			end
		end
	end

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
	input  logic                   clk,
	input  logic                   rst_n_i,
	rf_read_if.regfile             rd_port,
	input  logic                   we_i,
	input  logic [`REG_ADDR_W-1:0] waddr_i,
	input  logic [`XLEN-1:0]       wdata_i
);

	logic [`XLEN-1:0] regs [`NUM_REGS];
	logic             wr_hit;

	// x0 writes are dropped
	assign wr_hit = we_i && (waddr_i != rv_isa_pkg::reg_zero);

	// every register starts from zero
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// write-through means writeback needs no forward path
	assign rd_port.rdata1 = (!rd_port.re1 || rd_port.raddr1 == rv_isa_pkg::reg_zero) ? '0 :
		(wr_hit && rd_port.raddr1 == waddr_i) ? wdata_i : regs[rd_port.raddr1];
	assign rd_port.rdata2 = (!rd_port.re2 || rd_port.raddr2 == rv_isa_pkg::reg_zero) ? '0 :
		(wr_hit && rd_port.raddr2 == waddr_i) ? wdata_i : regs[rd_port.raddr2];

endmodule

// ==== verilog/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode (
	input  rv_pipe_pkg::if_id_t if_id_i,
	rf_read_if.decode           rf,
	fwd_if.consumer             ex_fwd,
	fwd_if.consumer             mem_fwd,
	output rv_pipe_pkg::id_ex_t id_ex_o,
	output logic                load_use_o
);

	logic [`XLEN-1:0]       inst;
	rv_isa_pkg::opcode_e    opcode;
	logic [2:0]             funct3;
	logic                   alt;
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic                   use_rs1;
	logic                   use_rs2;
	logic [`XLEN-1:0]       rs1_val;
	logic [`XLEN-1:0]       rs2_val;
	logic [`XLEN-1:0]       imm_i;
	logic [`XLEN-1:0]       imm_s;
	logic [`XLEN-1:0]       imm_b;
	logic [`XLEN-1:0]       imm_u;
	logic [`XLEN-1:0]       imm_j;

	// ----------------------------------------
	// fields and immediates
	// ----------------------------------------
	assign inst   = if_id_i.inst;
	assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign alt    = (inst[31:25] == rv_isa_pkg::f7_alt);
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// which sources are really read
	assign use_rs1 = opcode inside {rv_isa_pkg::op_reg, rv_isa_pkg::op_imm,
		rv_isa_pkg::op_load, rv_isa_pkg::op_store, rv_isa_pkg::op_branch};
	assign use_rs2 = opcode inside {rv_isa_pkg::op_reg, rv_isa_pkg::op_store,
		rv_isa_pkg::op_branch};

	assign rf.re1    = use_rs1;
	assign rf.re2    = use_rs2;
	assign rf.raddr1 = rs1;
	assign rf.raddr2 = rs2;

	// ----------------------------------------
	// operand forwarding
	// ----------------------------------------

	// execute is younger than memory and wins
	assign rs1_val = (rs1 == rv_isa_pkg::reg_zero) ? rf.rdata1 :
		(ex_fwd.we && ex_fwd.rd == rs1) ? ex_fwd.data :
		(mem_fwd.we && mem_fwd.rd == rs1) ? mem_fwd.data : rf.rdata1;
	assign rs2_val = (rs2 == rv_isa_pkg::reg_zero) ? rf.rdata2 :
		(ex_fwd.we && ex_fwd.rd == rs2) ? ex_fwd.data :
		(mem_fwd.we && mem_fwd.rd == rs2) ? mem_fwd.data : rf.rdata2;

	// a load still in execute has its data a cycle away
	assign load_use_o = ex_fwd.is_load && ex_fwd.we && (ex_fwd.rd != rv_isa_pkg::reg_zero)
		&& ((use_rs1 && ex_fwd.rd == rs1) || (use_rs2 && ex_fwd.rd == rs2));

	// funct3 group to alu op with sub only in the register form
	function automatic rv_isa_pkg::alu_op_e alu_dec(input logic is_reg);
		case (funct3)
			rv_isa_pkg::f3_add: return (alt && is_reg) ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
			rv_isa_pkg::f3_sll: return rv_isa_pkg::alu_sll;
			rv_isa_pkg::f3_slt: return rv_isa_pkg::alu_slt;
			rv_isa_pkg::f3_xor: return rv_isa_pkg::alu_xor;
			rv_isa_pkg::f3_sr:  return alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
			rv_isa_pkg::f3_or:  return rv_isa_pkg::alu_or;
			rv_isa_pkg::f3_and: return rv_isa_pkg::alu_and;
			default:            return rv_isa_pkg::alu_add;
		endcase
	endfunction

	// ----------------------------------------
	// control decode
	// ----------------------------------------
	always_comb begin
		// unknown encodings keep the bubble fields as a no-op
		id_ex_o            = rv_pipe_pkg::id_ex_bubble;
		id_ex_o.pc         = if_id_i.pc;
		id_ex_o.op_a       = rs1_val;
		id_ex_o.op_b       = rs2_val;
		id_ex_o.store_data = rs2_val;
		id_ex_o.rd         = inst[11:7];
		case (opcode)
			rv_isa_pkg::op_reg: begin
				id_ex_o.we     = (funct3 != rv_isa_pkg::f3_sltu);
				id_ex_o.alu_op = alu_dec(1'b1);
			end
			rv_isa_pkg::op_imm: begin
				id_ex_o.op_b   = imm_i;
				id_ex_o.we     = (funct3 != rv_isa_pkg::f3_sltu);
				id_ex_o.alu_op = alu_dec(1'b0);
			end
			rv_isa_pkg::op_lui: begin
				id_ex_o.op_b   = imm_u;
				id_ex_o.we     = 1'b1;
				id_ex_o.alu_op = rv_isa_pkg::alu_pass_b;
			end
			rv_isa_pkg::op_load: begin
				// address is rs1 + imm through the adder
				id_ex_o.op_b    = imm_i;
				id_ex_o.we      = (funct3 == rv_isa_pkg::f3_word);
				id_ex_o.is_load = (funct3 == rv_isa_pkg::f3_word);
			end
			rv_isa_pkg::op_store: begin
				id_ex_o.op_b     = imm_s;
				id_ex_o.is_store = (funct3 == rv_isa_pkg::f3_word);
			end
			rv_isa_pkg::op_branch: begin
				id_ex_o.br_off = imm_b;
				case (funct3)
					rv_isa_pkg::f3_beq: id_ex_o.br_op = rv_isa_pkg::br_eq;
					rv_isa_pkg::f3_bne: id_ex_o.br_op = rv_isa_pkg::br_ne;
					rv_isa_pkg::f3_blt: id_ex_o.br_op = rv_isa_pkg::br_lt;
					rv_isa_pkg::f3_bge: id_ex_o.br_op = rv_isa_pkg::br_ge;
					default:            id_ex_o.br_op = rv_isa_pkg::br_none;
				endcase
			end
			rv_isa_pkg::op_jal: begin
				id_ex_o.we     = 1'b1;
				id_ex_o.br_op  = rv_isa_pkg::br_jal;
				id_ex_o.br_off = imm_j;
			end
			default: ;
		endcase
	end

endmodule

// ==== verilog/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_execute (
	input  rv_pipe_pkg::id_ex_t  id_ex_i,
	fwd_if.producer              fwd,
	output rv_pipe_pkg::ex_mem_t ex_mem_o,
	output logic                 redirect_o,
	output logic [`XLEN-1:0]     target_o
);

	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [4:0]       shamt;
	logic             lt;
	logic [`XLEN-1:0] alu_res;
	logic [`XLEN-1:0] link;
	logic [`XLEN-1:0] result;

	assign a     = id_ex_i.op_a;
	assign b     = id_ex_i.op_b;
	assign shamt = b[4:0];

	// shared by slt and blt / bge
	assign lt = $signed(a) < $signed(b);

	// ----------------------------------------
	// alu
	// ----------------------------------------
	always_comb begin
		case (id_ex_i.alu_op)
			rv_isa_pkg::alu_sub:    alu_res = a - b;
			rv_isa_pkg::alu_and:    alu_res = a & b;
			rv_isa_pkg::alu_or:     alu_res = a | b;
			rv_isa_pkg::alu_xor:    alu_res = a ^ b;
			rv_isa_pkg::alu_slt:    alu_res = {{(`XLEN-1){1'b0}}, lt};
			rv_isa_pkg::alu_sll:    alu_res = a << shamt;
			rv_isa_pkg::alu_srl:    alu_res = a >> shamt;
			rv_isa_pkg::alu_sra:    alu_res = $unsigned($signed(a) >>> shamt);
			rv_isa_pkg::alu_pass_b: alu_res = b;
			// add, also the lw / sw address
			default:                alu_res = a + b;
		endcase
	end

	// ----------------------------------------
	// branch resolve
	// ----------------------------------------
	always_comb begin
		case (id_ex_i.br_op)
			rv_isa_pkg::br_eq:  redirect_o = (a == b);
			rv_isa_pkg::br_ne:  redirect_o = (a != b);
			rv_isa_pkg::br_lt:  redirect_o = lt;
			rv_isa_pkg::br_ge:  redirect_o = !lt;
			rv_isa_pkg::br_jal: redirect_o = 1'b1;
			default:            redirect_o = 1'b0;
		endcase
	end

	assign target_o = id_ex_i.pc + id_ex_i.br_off;
	assign link     = id_ex_i.pc + `XLEN'd4;

	// jal writes the return address instead
	assign result = (id_ex_i.br_op == rv_isa_pkg::br_jal) ? link : alu_res;

	assign ex_mem_o = '{
		result:     result,
		store_data: id_ex_i.store_data,
		rd:         id_ex_i.rd,
		we:         id_ex_i.we,
		is_load:    id_ex_i.is_load,
		is_store:   id_ex_i.is_store
	};

	// forward to decode, loads only flag the hazard
	assign fwd.rd      = id_ex_i.rd;
	assign fwd.we      = id_ex_i.we;
	assign fwd.data    = result;
	assign fwd.is_load = id_ex_i.is_load;

endmodule

// ==== verilog/rv32i_core.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv32i_core (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic [`XLEN-1:0]   rom_data_i,
	output logic [`XLEN-1:0]   rom_addr_o,
	output logic               rom_ce_o,
	input  logic [`XLEN-1:0]   mem_data_i,
	output logic               mem_ce_o,
	output logic [`XLEN-1:0]   mem_data_o,
	output logic [`XLEN-1:0]   mem_addr_o,
	output logic               mem_we_o,
	output logic [`SEL_W-1:0]  mem_sel_o
);

	rv_pipe_pkg::if_id_t  if_d, if_q;
	rv_pipe_pkg::id_ex_t  id_d, id_q;
	rv_pipe_pkg::ex_mem_t ex_d, ex_q;
	rv_pipe_pkg::mem_wb_t wb_d, wb_q;
	rv_pipe_pkg::stall_t  stall;
	logic                 flush;
	logic                 load_use;
	logic                 redirect;
	logic [`XLEN-1:0]     target;

	rf_read_if rf_rd ();
	fwd_if     ex_fwd ();
	fwd_if     mem_fwd ();

	// ----------------------------------------
	// fetch
	// ----------------------------------------
	rv_fetch_ctrl u_fetch (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.load_use_i (load_use),
		.redirect_i (redirect),
		.target_i   (target),
		.pc_o       (rom_addr_o),
		.fetch_en_o (rom_ce_o),
		.stall_o    (stall),
		.flush_o    (flush)
	);

	assign if_d = '{pc: rom_addr_o, inst: rom_data_i};

	// no fetch yet, feed a bubble
	pipe_reg #(.payload_t(rv_pipe_pkg::if_id_t), .bubble(rv_pipe_pkg::if_id_bubble)) u_if_id (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall.if_id),
		.flush_i(flush | ~rom_ce_o), .d_i(if_d), .q_o(if_q)
	);

	// ----------------------------------------
	// decode, execute
	// ----------------------------------------
	rv_regfile u_regfile (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.rd_port (rf_rd),
		.we_i    (wb_q.we),
		.waddr_i (wb_q.rd),
		.wdata_i (wb_q.wdata)
	);

	rv_decode u_decode (
		.if_id_i    (if_q),
		.rf         (rf_rd),
		.ex_fwd     (ex_fwd),
		.mem_fwd    (mem_fwd),
		.id_ex_o    (id_d),
		.load_use_o (load_use)
	);

	// held decode slot leaves a bubble behind it
	pipe_reg #(.payload_t(rv_pipe_pkg::id_ex_t), .bubble(rv_pipe_pkg::id_ex_bubble)) u_id_ex (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall.id_ex),
		.flush_i(flush | stall.if_id), .d_i(id_d), .q_o(id_q)
	);

	rv_execute u_execute (
		.id_ex_i    (id_q),
		.fwd        (ex_fwd),
		.ex_mem_o   (ex_d),
		.redirect_o (redirect),
		.target_o   (target)
	);

	pipe_reg #(.payload_t(rv_pipe_pkg::ex_mem_t), .bubble(rv_pipe_pkg::ex_mem_bubble)) u_ex_mem (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall.ex_mem),
		.flush_i(1'b0), .d_i(ex_d), .q_o(ex_q)
	);

	// ----------------------------------------
	// memory stage, wiring only
	// ----------------------------------------
	assign mem_ce_o   = ex_q.is_load | ex_q.is_store;
	assign mem_we_o   = ex_q.is_store;
	assign mem_addr_o = ex_q.result;
	assign mem_data_o = ex_q.store_data;
	// word accesses only
	assign mem_sel_o  = {`SEL_W{1'b1}};

	assign wb_d = '{
		rd:    ex_q.rd,
		we:    ex_q.we,
		wdata: ex_q.is_load ? mem_data_i : ex_q.result
	};

	// load data arrives here, so it can forward now
	assign mem_fwd.rd      = wb_d.rd;
	assign mem_fwd.we      = wb_d.we;
	assign mem_fwd.data    = wb_d.wdata;
	assign mem_fwd.is_load = ex_q.is_load;

	pipe_reg #(.payload_t(rv_pipe_pkg::mem_wb_t), .bubble(rv_pipe_pkg::mem_wb_bubble)) u_mem_wb (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall.mem_wb),
		.flush_i(1'b0), .d_i(wb_d), .q_o(wb_q)
	);

endmodule

// ==== verification/tb_rv32i_ref.svh ====
`ifndef TB_RV32I_REF_SVH
`define TB_RV32I_REF_SVH

// ----------------------------------------
// random source and memory fill
// ----------------------------------------
function automatic logic [31:0] xorshift32();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// initial data word, mixes every address bit
function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
	return (byte_addr * 32'h9e37_79b9) ^ 32'h0bad_f00d;
endfunction

// ----------------------------------------
// instruction encoders
// ----------------------------------------
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

// sw rs2, imm(rs1)
function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
	return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// ----------------------------------------
// program builders
// ----------------------------------------
task automatic emit(input logic [31:0] word);
	prog[prog_len] = word;
	prog_len++;
endtask

// dump x1..x31 above the scratch area, then spin on a self-jal
task automatic finish_prog();
	int r;
	for (r = 1; r < 32; r++) begin
		emit(s_type(12'h300 + 12'(4 * r), 5'(r), 5'd0));
	end
	emit(j_type(5'd0, 21'd0));
endtask

task automatic alu_program();
	prog_len = 0;
	emit(u_type(20'h12345, 5'd1));
	emit(i_type(12'h678, 5'd1, 3'd0, 5'd1, 7'h13));
	emit(i_type(12'hfff, 5'd1, 3'd0, 5'd2, 7'h13));
	emit(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
	emit(s_type(12'h000, 5'd3, 5'd0));
	emit(r_type(7'h00, 5'd1, 5'd3, 3'd4, 5'd4));
	emit(i_type(12'h003, 5'd4, 3'd1, 5'd5, 7'h13));
	emit(i_type(12'h402, 5'd5, 3'd5, 5'd6, 7'h13));
	emit(i_type(12'h002, 5'd5, 3'd5, 5'd7, 7'h13));
	emit(s_type(12'h004, 5'd7, 5'd0));
	emit(r_type(7'h00, 5'd1, 5'd6, 3'd2, 5'd8));
	emit(i_type(12'h005, 5'd6, 3'd2, 5'd9, 7'h13));
	emit(s_type(12'h008, 5'd8, 5'd0));
	emit(r_type(7'h00, 5'd4, 5'd1, 3'd7, 5'd10));
	emit(r_type(7'h00, 5'd2, 5'd10, 3'd6, 5'd11));
	emit(i_type(12'h0f0, 5'd11, 3'd7, 5'd12, 7'h13));
	emit(i_type(12'h700, 5'd12, 3'd6, 5'd13, 7'h13));
	emit(i_type(12'hfff, 5'd13, 3'd4, 5'd14, 7'h13));
	emit(r_type(7'h00, 5'd9, 5'd1, 3'd1, 5'd15));
	emit(r_type(7'h20, 5'd9, 5'd3, 3'd5, 5'd16));
	emit(r_type(7'h00, 5'd9, 5'd3, 3'd5, 5'd17));
	// write to x0 must not stick
	emit(i_type(12'h005, 5'd1, 3'd0, 5'd0, 7'h13));
	emit(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd18));
	emit(s_type(12'h00c, 5'd18, 5'd0));
	finish_prog();
endtask

task automatic load_use_program();
	prog_len = 0;
	emit(i_type(12'h055, 5'd0, 3'd0, 5'd1, 7'h13));
	emit(s_type(12'h010, 5'd1, 5'd0));
	emit(i_type(12'h010, 5'd0, 3'd2, 5'd2, 7'h03));
	emit(r_type(7'h00, 5'd2, 5'd2, 3'd0, 5'd3));
	emit(s_type(12'h014, 5'd3, 5'd0));
	// loaded value feeds store data directly
	emit(i_type(12'h014, 5'd0, 3'd2, 5'd4, 7'h03));
	emit(s_type(12'h018, 5'd4, 5'd0));
	emit(i_type(12'h020, 5'd0, 3'd2, 5'd5, 7'h03));
	emit(i_type(12'h001, 5'd5, 3'd0, 5'd6, 7'h13));
	emit(s_type(12'h01c, 5'd6, 5'd0));
	finish_prog();
endtask

// taken branch skips the first store
task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
	emit(i_type(12'h001, 5'd20, 3'd0, 5'd20, 7'h13));
	emit(b_type(f3, rs1, rs2, 13'd8));
	emit(s_type(12'h100, 5'd20, 5'd0));
	emit(s_type(12'h104, 5'd20, 5'd0));
endtask

task automatic branch_program();
	prog_len = 0;
	emit(i_type(12'h005, 5'd0, 3'd0, 5'd1, 7'h13));
	emit(i_type(12'hffd, 5'd0, 3'd0, 5'd2, 7'h13));
	branch_case(3'd0, 5'd1, 5'd1);
	branch_case(3'd0, 5'd1, 5'd2);
	branch_case(3'd1, 5'd1, 5'd2);
	branch_case(3'd1, 5'd1, 5'd1);
	branch_case(3'd4, 5'd2, 5'd1);
	branch_case(3'd4, 5'd1, 5'd2);
	branch_case(3'd5, 5'd1, 5'd2);
	branch_case(3'd5, 5'd2, 5'd1);
	branch_case(3'd5, 5'd1, 5'd1);
	// jal over a wrong-path store, then keep the link
	emit(j_type(5'd5, 21'd8));
	emit(s_type(12'h108, 5'd1, 5'd0));
	emit(s_type(12'h10c, 5'd5, 5'd0));
	finish_prog();
endtask

task automatic random_program(input int n);
	int i;
	logic [31:0] r;
	logic [2:0] f3;
	logic [11:0] imm;
	logic [2:0] alu_f3 [7] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};
	prog_len = 0;
	for (i = 0; i < n; i++) begin
		r = xorshift32();
		f3 = alu_f3[r[10:8] % 7];
		// shifts need a clean funct7 field
		if (f3 == 3'd1 || f3 == 3'd5) begin
			imm = {(f3 == 3'd5 && r[11]) ? 7'h20 : 7'h00, r[16:12]};
		end else begin
			imm = r[23:12];
		end
		case (r[2:0])
			3'd0, 3'd1: emit(r_type(((f3 == 3'd0 || f3 == 3'd5) && r[11]) ? 7'h20 : 7'h00,
				5'(r[27:24]), 5'(r[31:28]), f3, 5'(r[7:4])));
			3'd2, 3'd3: emit(i_type(imm, 5'(r[31:28]), f3, 5'(r[7:4]), 7'h13));
			3'd4: emit(u_type(r[31:12], 5'(r[7:4])));
			3'd5: emit(i_type(12'(4 * (r[23:12] % 192)), 5'd0, 3'd2, 5'(r[7:4]), 7'h03));
			3'd6: emit(s_type(12'(4 * (r[23:12] % 192)), 5'(r[27:24]), 5'd0));
			default: begin
				if (i + 4 < n) begin
					emit(b_type(alu_f3[r[10:8] % 4] & 3'b101, 5'(r[31:28]), 5'(r[27:24]),
						13'(4 * (2 + r[13:12] % 3))));
				end else begin
					emit(i_type(imm, 5'(r[31:28]), 3'd0, 5'(r[7:4]), 7'h13));
				end
			end
		endcase
	end
	finish_prog();
endtask

// ----------------------------------------
// architectural model, fills the expected store list
// ----------------------------------------
function automatic int ref_run();
	logic [31:0] regs [32];
	logic [31:0] mem [256];
	logic [31:0] pc, npc, w, a, b, res, ea;
	logic [2:0]  f3;
	logic        wr;
	logic        taken;
	int          i;
	int          n;
	bit          done;
	for (i = 0; i < 32; i++) regs[i] = '0;
	for (i = 0; i < 256; i++) mem[i] = fill_word(32'(i * 4));
	pc = `RESET_PC;
	n = 0;
	done = 0;
	while (!done && n < 4096) begin
		w = (pc[31:2] < prog_len) ? prog[pc[11:2]] : `NOP_INST;
		f3 = w[14:12];
		a = regs[w[19:15]];
		b = regs[w[24:20]];
		wr = 0;
		res = '0;
		npc = pc + 4;
		n++;
		case (w[6:0])
			7'h33, 7'h13: begin
				if (w[6:0] == 7'h13) b = {{20{w[31]}}, w[31:20]};
				wr = 1;
				case (f3)
					3'd0: res = (w[5] && w[30]) ? a - b : a + b;
					3'd1: res = a << b[4:0];
					3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'd4: res = a ^ b;
					3'd5: begin
						if (w[30]) res = $signed(a) >>> b[4:0];
						else res = a >> b[4:0];
					end
					3'd6: res = a | b;
					3'd7: res = a & b;
					// sltu is not kept
					default: wr = 0;
				endcase
			end
			7'h37: begin
				res = {w[31:12], 12'b0};
				wr = 1;
			end
			7'h03: begin
				ea = a + {{20{w[31]}}, w[31:20]};
				res = mem[ea[9:2]];
				wr = (f3 == 3'd2);
			end
			7'h23: begin
				if (f3 == 3'd2) begin
					ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
					mem[ea[9:2]] = b;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
				end
			end
			7'h63: begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					default: taken = 0;
				endcase
				if (taken) npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			end
			7'h6f: begin
				res = pc + 4;
				wr = 1;
				npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				done = (npc == pc);
			end
			default: ;
		endcase
		if (wr) regs[w[11:7]] = res;
		regs[0] = '0;
		pc = npc;
	end
	return n;
endfunction

`endif

// ==== verification/tb_rv32i.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv32i;

	logic                 clk;
	logic                 rst_n_i;
	logic [`XLEN-1:0]     rom_data_i;
	logic [`XLEN-1:0]     rom_addr_o;
	logic                 rom_ce_o;
	logic [`XLEN-1:0]     mem_data_i;
	logic                 mem_ce_o;
	logic [`XLEN-1:0]     mem_data_o;
	logic [`XLEN-1:0]     mem_addr_o;
	logic                 mem_we_o;
	logic [`SEL_W-1:0]    mem_sel_o;

	logic [`XLEN-1:0] prog [1024];
	int               prog_len = 0;
	logic [`XLEN-1:0] dmem [256];
	logic [`XLEN-1:0] exp_addr [$];
	logic [`XLEN-1:0] exp_data [$];
	int               store_idx = 0;
	bit               running = 0;
	int               cyc_count = 0;
	int               cyc_limit = 0;
	logic [31:0]      rng_state = 32'h9a83_6418;

	`include "tb_rv32i_ref.svh"

	rv32i_core uut (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rom_data_i (rom_data_i),
		.rom_addr_o (rom_addr_o),
		.rom_ce_o   (rom_ce_o),
		.mem_data_i (mem_data_i),
		.mem_ce_o   (mem_ce_o),
		.mem_data_o (mem_data_o),
		.mem_addr_o (mem_addr_o),
		.mem_we_o   (mem_we_o),
		.mem_sel_o  (mem_sel_o)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	initial rst_n_i = 1'b0;

	// ----------------------------------------
	// memory models
	// ----------------------------------------

	// nop outside the loaded program
	assign rom_data_i = (rom_addr_o[31:2] < prog_len) ? prog[rom_addr_o[11:2]] : `NOP_INST;
	assign mem_data_i = dmem[mem_addr_o[9:2]];

	always @(posedge clk) begin
		if (rst_n_i && mem_ce_o && mem_we_o) begin
			dmem[mem_addr_o[9:2]] <= mem_data_o;
		end
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
		input string name);
		if (got !== exp) begin
			report_failure($sformatf("Fail %s: got %08h expected %08h", name, got, exp));
		end
	endtask

	task automatic expect_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic expect_sel(input logic [`SEL_W-1:0] got, input logic [`SEL_W-1:0] exp,
		input string name);
		if (got !== exp) begin
			report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
		end
	endtask

	// ----------------------------------------
	// store monitor and watchdog
	// ----------------------------------------
	always @(negedge clk) begin
		if (running && rst_n_i && mem_ce_o && mem_we_o) begin
			if (store_idx >= exp_addr.size()) begin
				report_failure($sformatf("an extra store to address %08h appeared after %0d",
					mem_addr_o, exp_addr.size()));
			end else begin
				check_word(mem_addr_o, exp_addr[store_idx], "mem_addr_o");
				check_word(mem_data_o, exp_data[store_idx], "mem_data_o");
				expect_sel(mem_sel_o, {`SEL_W{1'b1}}, "mem_sel_o");
				store_idx++;
			end
		end
	end

	always @(posedge clk) begin
		if (running) begin
			cyc_count++;
			if (cyc_count > cyc_limit) begin
				report_failure($sformatf("timeout, only %0d of %0d stores were seen",
					store_idx, exp_addr.size()));
			end
		end
	end

	// reset the core, run to the self-jal and match every store
	task automatic run_program(input string name);
		int ninst;
		int nstores;
		int k;
		exp_addr.delete();
		exp_data.delete();
		ninst = ref_run();
		nstores = exp_addr.size();
		@(posedge clk);
		running = 0;
		rst_n_i <= 1'b0;
		for (k = 0; k < 256; k++) dmem[k] = fill_word(32'(k * 4));
		for (k = 0; k < 5; k++) begin
			@(negedge clk);
			// the first edge only starts the reset
			if (k > 0) begin
				expect_bit(rom_ce_o, 1'b0, "rom_ce_o");
				expect_bit(mem_ce_o, 1'b0, "mem_ce_o");
				expect_bit(mem_we_o, 1'b0, "mem_we_o");
			end
			@(posedge clk);
		end
		rst_n_i <= 1'b1;
		store_idx = 0;
		cyc_count = 0;
		cyc_limit = ninst * 8 + 64;
		running = 1;
		@(negedge clk);
		@(negedge clk);
		expect_bit(rom_ce_o, 1'b1, "rom_ce_o");
		check_word(rom_addr_o, `RESET_PC, "rom_addr_o");
		wait (store_idx == nstores);
		// room for a stray store to show up
		repeat (16) @(posedge clk);
		running = 0;
		$display("program %s: %0d instructions, %0d stores matched", name, ninst, store_idx);
	endtask

	initial begin
		int p;
		alu_program();
		run_program("alu");
		load_use_program();
		run_program("load_use");
		branch_program();
		run_program("branch");
		for (p = 0; p < 4; p++) begin
			random_program(40);
			run_program($sformatf("random_%0d", p));
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+verilog
+incdir+verification
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_ifs.sv
verilog/pipe_reg.sv
verilog/rv_fetch_ctrl.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv32i_core.sv
verification/tb_rv32i.sv

// ==== Bender.yml ====
package:
  name: rv32i_pipeline

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/rv_pipe_pkg.sv
      - verilog/rv_ifs.sv
      - verilog/pipe_reg.sv
      - verilog/rv_fetch_ctrl.sv
      - verilog/rv_regfile.sv
      - verilog/rv_decode.sv
      - verilog/rv_execute.sv
      - verilog/rv32i_core.sv
  - target: test
    include_dirs:
      - verilog
      - verification
    files:
      - verification/tb_rv32i.sv
